//--- hdl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // default datapath width
    localparam int data_width = 32;

    // lane-0 operations, lane 1 is always plain alu
    typedef enum logic [2:0] {
        op_nop     = 3'd0,
        op_alu     = 3'd1,
        op_div     = 3'd2,
        op_mod     = 3'd3,
        op_csrrd   = 3'd4,
        op_csrxchg = 3'd5,
        op_syscall = 3'd6,
        op_ertn    = 3'd7
    } op_e;

    // csr addresses as in the loongarch csr map
    typedef enum logic [13:0] {
        csr_estat  = 14'h005,
        csr_era    = 14'h006,
        csr_badv   = 14'h007,
        csr_eentry = 14'h00c,
        csr_save0  = 14'h030
    } csr_num_e;

    // estat[21:16] on syscall
    localparam logic [5:0] ecode_sys = 6'h0b;

endpackage

`default_nettype wire

//--- hdl/int_divider.sv
`timescale 1ns/1ps
`default_nettype none

module int_divider import wb_pkg::*; #(
    parameter int DATA_WIDTH = data_width
) (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  div_start,
    input  logic [DATA_WIDTH-1:0] dividend,
    input  logic [DATA_WIDTH-1:0] divisor,
    output logic [DATA_WIDTH-1:0] quotient,
    output logic [DATA_WIDTH-1:0] remainder,
    output logic                  div_done
);

    localparam int CNT_W = $clog2(DATA_WIDTH);

    typedef enum logic {
        div_idle,
        div_run
    } div_state_e;

    div_state_e            state;
    logic [CNT_W-1:0]      count;
    logic [DATA_WIDTH-1:0] divisor_q;
    logic [DATA_WIDTH:0]   shifted;
    logic [DATA_WIDTH:0]   diff;

    // partial remainder with the next dividend bit shifted in
    assign shifted = {remainder, quotient[DATA_WIDTH-1]};
    assign diff    = shifted - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state    <= div_idle;
            count    <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            case (state)
                div_idle: begin
                    if (div_start) begin
                        state <= div_run;
                        count <= '0;
                    end
                end
                div_run: begin
                    count <= count + 1'b1;
                    // last quotient bit goes in on this edge
                    if (count == CNT_W'(DATA_WIDTH - 1)) begin
                        state    <= div_idle;
                        div_done <= 1'b1;
                    end
                end
                default: begin
                    state <= div_idle;
                end
            endcase
        end
    end

    // quotient register doubles as the dividend shifter
    always_ff @(posedge clk) begin
        if (state == div_idle) begin
            if (div_start) begin
                quotient  <= dividend;
                remainder <= '0;
                divisor_q <= divisor;
            end
        end else begin
            // restore when the trial subtraction goes negative
            if (diff[DATA_WIDTH]) begin
                remainder <= shifted[DATA_WIDTH-1:0];
            end else begin
                remainder <= diff[DATA_WIDTH-1:0];
            end
            quotient <= {quotient[DATA_WIDTH-2:0], ~diff[DATA_WIDTH]};
        end
    end

    // zero divisor: every trial succeeds, so quotient is all ones and
    // the dividend ends up shifted whole into the remainder

endmodule

`default_nettype wire

//--- hdl/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit import wb_pkg::*; #(
    parameter int DATA_WIDTH = data_width
) (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  csr_re,
    input  logic                  csr_we,
    input  csr_num_e              csr_num,
    input  logic [DATA_WIDTH-1:0] csr_wdata,
    output logic [DATA_WIDTH-1:0] csr_rdata,
    input  logic                  exc_enter,
    input  logic                  exc_return,
    input  logic [DATA_WIDTH-1:0] exc_pc,
    input  logic [5:0]            exc_ecode,
    output logic [DATA_WIDTH-1:0] era,
    output logic [DATA_WIDTH-1:0] eentry
);

    // estat layout
    localparam int PRV_BIT   = 2;
    localparam int PPRV_BIT  = 3;
    localparam int ECODE_LO  = 16;
    localparam int ECODE_HI  = 21;

    localparam logic [DATA_WIDTH-1:0] EENTRY_RST = DATA_WIDTH'(32'h1c000000);

    logic [DATA_WIDTH-1:0] estat;
    logic [DATA_WIDTH-1:0] badv;
    logic [DATA_WIDTH-1:0] save0;

    // read port, old value is what csrxchg hands back
    always_comb begin
        csr_rdata = '0;
        if (csr_re) begin
            case (csr_num)
                csr_estat:  csr_rdata = estat;
                csr_era:    csr_rdata = era;
                csr_badv:   csr_rdata = badv;
                csr_eentry: csr_rdata = eentry;
                csr_save0:  csr_rdata = save0;
                default:    csr_rdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat  <= '0;
            era    <= '0;
            badv   <= '0;
            eentry <= EENTRY_RST;
            save0  <= '0;
        end else if (exc_enter) begin
            era                      <= exc_pc;
            estat[ECODE_HI:ECODE_LO] <= exc_ecode;
            // drop to kernel, remember where we came from
            estat[PPRV_BIT]          <= estat[PRV_BIT];
            estat[PRV_BIT]           <= 1'b0;
        end else if (exc_return) begin
            estat[PRV_BIT] <= estat[PPRV_BIT];
        end else if (csr_we) begin
            case (csr_num)
                csr_estat:  estat  <= csr_wdata;
                csr_era:    era    <= csr_wdata;
                csr_badv:   badv   <= csr_wdata;
                csr_eentry: eentry <= csr_wdata;
                csr_save0:  save0  <= csr_wdata;
                default: begin
                    save0 <= save0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import wb_pkg::*; #(
    parameter int DATA_WIDTH = data_width
) (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  issue_valid,
    input  logic                  lane1_valid,
    input  op_e                   op0,
    input  logic [DATA_WIDTH-1:0] pc0,
    input  logic [4:0]            rd0,
    input  logic [4:0]            rd1,
    input  logic [DATA_WIDTH-1:0] result0,
    input  logic [DATA_WIDTH-1:0] result1,
    input  logic [DATA_WIDTH-1:0] dividend,
    input  logic [DATA_WIDTH-1:0] divisor,
    input  logic [DATA_WIDTH-1:0] csr_wdata,
    input  csr_num_e              csr_num,
    // divider side
    output logic                  div_start,
    output logic [DATA_WIDTH-1:0] div_dividend,
    output logic [DATA_WIDTH-1:0] div_divisor,
    input  logic [DATA_WIDTH-1:0] quotient,
    input  logic [DATA_WIDTH-1:0] remainder,
    input  logic                  div_done,
    // csr side
    output logic                  csr_re,
    output logic                  csr_we,
    output csr_num_e              unit_csr_num,
    output logic [DATA_WIDTH-1:0] unit_csr_wdata,
    output logic                  exc_enter,
    output logic                  exc_return,
    output logic [DATA_WIDTH-1:0] exc_pc,
    output logic [5:0]            exc_ecode,
    input  logic [DATA_WIDTH-1:0] csr_rdata,
    input  logic [DATA_WIDTH-1:0] era,
    input  logic [DATA_WIDTH-1:0] eentry,
    // towards issue and register file
    output logic                  allowin,
    output logic                  wen0,
    output logic                  wen1,
    output logic [4:0]            waddr0,
    output logic [4:0]            waddr1,
    output logic [DATA_WIDTH-1:0] wdata0,
    output logic [DATA_WIDTH-1:0] wdata1,
    output logic                  redirect_valid,
    output logic [DATA_WIDTH-1:0] redirect_pc
);

    typedef enum logic {
        wb_idle,
        wb_wait_div
    } wb_state_e;

    wb_state_e  state;
    logic       accept;
    logic       is_div;
    logic       is_sys;
    logic       mod_hold;
    logic [4:0] rd0_hold;

    // only a running divide blocks the stage
    assign allowin = (state == wb_idle);
    assign accept  = issue_valid && allowin;
    assign is_div  = (op0 == op_div) || (op0 == op_mod);
    assign is_sys  = (op0 == op_syscall);

    assign div_start    = accept && is_div;
    assign div_dividend = dividend;
    assign div_divisor  = divisor;

    assign csr_re         = accept && ((op0 == op_csrrd) || (op0 == op_csrxchg));
    assign csr_we         = accept && (op0 == op_csrxchg);
    assign unit_csr_num   = csr_num;
    assign unit_csr_wdata = csr_wdata;
    assign exc_enter      = accept && is_sys;
    assign exc_return     = accept && (op0 == op_ertn);
    assign exc_pc         = pc0;
    assign exc_ecode      = ecode_sys;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= wb_idle;
        end else begin
            case (state)
                wb_idle: begin
                    if (div_start) begin
                        state <= wb_wait_div;
                    end
                end
                wb_wait_div: begin
                    if (div_done) begin
                        state <= wb_idle;
                    end
                end
                default: begin
                    state <= wb_idle;
                end
            endcase
        end
    end

    // destination and div/mod choice kept while the divider runs
    always_ff @(posedge clk) begin
        if (div_start) begin
            rd0_hold <= rd0;
            mod_hold <= (op0 == op_mod);
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wen0           <= 1'b0;
            wen1           <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wen0           <= (accept && (op0 == op_alu)) || csr_re ||
                              ((state == wb_wait_div) && div_done);
            // syscall kills the younger lane
            wen1           <= accept && lane1_valid && !is_sys;
            redirect_valid <= exc_enter || exc_return;
        end
    end

    always_ff @(posedge clk) begin
        if (state == wb_wait_div) begin
            waddr0 <= rd0_hold;
            wdata0 <= mod_hold ? remainder : quotient;
        end else begin
            waddr0 <= rd0;
            wdata0 <= (op0 == op_alu) ? result0 : csr_rdata;
        end
        waddr1      <= rd1;
        wdata1      <= result1;
        redirect_pc <= is_sys ? eentry : era;
    end

endmodule

`default_nettype wire

//--- hdl/exec_backend.sv
`timescale 1ns/1ps
`default_nettype none

module exec_backend import wb_pkg::*; #(
    parameter int DATA_WIDTH = data_width
) (
    input  logic                  clk,
    input  logic                  aresetn,
    // issue bundle
    input  logic                  issue_valid,
    input  logic [DATA_WIDTH-1:0] pc0,
    input  logic [DATA_WIDTH-1:0] pc1,
    input  op_e                   op0,
    input  logic [4:0]            rd0,
    input  logic [DATA_WIDTH-1:0] result0,
    input  csr_num_e              csr_num,
    input  logic [DATA_WIDTH-1:0] csr_wdata,
    input  logic [DATA_WIDTH-1:0] dividend,
    input  logic [DATA_WIDTH-1:0] divisor,
    input  logic                  lane1_valid,
    input  logic [4:0]            rd1,
    input  logic [DATA_WIDTH-1:0] result1,
    output logic                  allowin,
    // register file write ports
    output logic                  wen0,
    output logic [4:0]            waddr0,
    output logic [DATA_WIDTH-1:0] wdata0,
    output logic                  wen1,
    output logic [4:0]            waddr1,
    output logic [DATA_WIDTH-1:0] wdata1,
    // fetch redirect
    output logic                  redirect_valid,
    output logic [DATA_WIDTH-1:0] redirect_pc
);

    logic                  div_start;
    logic [DATA_WIDTH-1:0] div_dividend;
    logic [DATA_WIDTH-1:0] div_divisor;
    logic [DATA_WIDTH-1:0] quotient;
    logic [DATA_WIDTH-1:0] remainder;
    logic                  div_done;
    logic                  csr_re;
    logic                  csr_we;
    csr_num_e              unit_csr_num;
    logic [DATA_WIDTH-1:0] unit_csr_wdata;
    logic [DATA_WIDTH-1:0] csr_rdata;
    logic                  exc_enter;
    logic                  exc_return;
    logic [DATA_WIDTH-1:0] exc_pc;
    logic [5:0]            exc_ecode;
    logic [DATA_WIDTH-1:0] era;
    logic [DATA_WIDTH-1:0] eentry;

    int_divider #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_divider (
        .clk       (clk),
        .aresetn   (aresetn),
        .div_start (div_start),
        .dividend  (div_dividend),
        .divisor   (div_divisor),
        .quotient  (quotient),
        .remainder (remainder),
        .div_done  (div_done)
    );

    csr_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_csr (
        .clk        (clk),
        .aresetn    (aresetn),
        .csr_re     (csr_re),
        .csr_we     (csr_we),
        .csr_num    (unit_csr_num),
        .csr_wdata  (unit_csr_wdata),
        .csr_rdata  (csr_rdata),
        .exc_enter  (exc_enter),
        .exc_return (exc_return),
        .exc_pc     (exc_pc),
        .exc_ecode  (exc_ecode),
        .era        (era),
        .eentry     (eentry)
    );

    writeback_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_wb (
        .clk            (clk),
        .aresetn        (aresetn),
        .issue_valid    (issue_valid),
        .lane1_valid    (lane1_valid),
        .op0            (op0),
        .pc0            (pc0),
        .rd0            (rd0),
        .rd1            (rd1),
        .result0        (result0),
        .result1        (result1),
        .dividend       (dividend),
        .divisor        (divisor),
        .csr_wdata      (csr_wdata),
        .csr_num        (csr_num),
        .div_start      (div_start),
        .div_dividend   (div_dividend),
        .div_divisor    (div_divisor),
        .quotient       (quotient),
        .remainder      (remainder),
        .div_done       (div_done),
        .csr_re         (csr_re),
        .csr_we         (csr_we),
        .unit_csr_num   (unit_csr_num),
        .unit_csr_wdata (unit_csr_wdata),
        .exc_enter      (exc_enter),
        .exc_return     (exc_return),
        .exc_pc         (exc_pc),
        .exc_ecode      (exc_ecode),
        .csr_rdata      (csr_rdata),
        .era            (era),
        .eentry         (eentry),
        .allowin        (allowin),
        .wen0           (wen0),
        .wen1           (wen1),
        .waddr0         (waddr0),
        .waddr1         (waddr1),
        .wdata0         (wdata0),
        .wdata1         (wdata1),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- bench/exec_backend_properties.sv
`timescale 1ns/1ps
`default_nettype none

module exec_backend_properties import wb_pkg::*; (
    input logic clk,
    input logic aresetn,
    input logic issue_valid,
    input logic lane1_valid,
    input op_e  op0,
    input logic allowin,
    input logic div_start,
    input logic div_done,
    input logic redirect_valid,
    input logic wen1
);

    int unsigned fail_count = 0;
    logic        div_busy;

    // divider owned from its start until the done pulse
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            div_busy <= 1'b0;
        end else if (div_start) begin
            div_busy <= 1'b1;
        end else if (div_done) begin
            div_busy <= 1'b0;
        end
    end

    no_div_restart: assert property (@(posedge clk) disable iff (!aresetn)
        (div_busy && !div_done) |-> !div_start)
    else begin
        $error("div_start raised while the divider runs");
        fail_count++;
    end

    done_only_when_busy: assert property (@(posedge clk) disable iff (!aresetn)
        div_done |-> !allowin)
    else begin
        $error("div_done seen while the stage was not waiting");
        fail_count++;
    end

    redirect_one_cycle: assert property (@(posedge clk) disable iff (!aresetn)
        redirect_valid |=> !redirect_valid)
    else begin
        $error("redirect_valid held for more than one cycle");
        fail_count++;
    end

    // syscall kills lane 1 of its own bundle
    syscall_kills_lane1: assert property (@(posedge clk) disable iff (!aresetn)
        (issue_valid && allowin && lane1_valid && (op0 == op_syscall))
            |=> (redirect_valid && !wen1))
    else begin
        $error("lane 1 written or no redirect after syscall");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- bench/exec_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_backend_tb import wb_pkg::*; ();

    localparam int DW          = 32;
    localparam int ALLOW_LIMIT = 50;
    localparam int DIV_LIMIT   = 40;
    localparam int DIV_LATENCY = 33;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rd0;
        logic [31:0] data0;
        csr_num_e    csr;
        logic        zero_div;
        logic        lane1;
        logic [4:0]  rd1;
        logic [31:0] result1;
        logic        exp_wen0;
        logic        exp_wen1;
        logic        exp_redir;
    } row_t;

    logic          clk;
    logic          aresetn;
    logic          issue_valid;
    logic [DW-1:0] pc0;
    logic [DW-1:0] pc1;
    op_e           op0;
    logic [4:0]    rd0;
    logic [DW-1:0] result0;
    csr_num_e      csr_num;
    logic [DW-1:0] csr_wdata;
    logic [DW-1:0] dividend;
    logic [DW-1:0] divisor;
    logic          lane1_valid;
    logic [4:0]    rd1;
    logic [DW-1:0] result1;
    logic          allowin;
    logic          wen0;
    logic [4:0]    waddr0;
    logic [DW-1:0] wdata0;
    logic          wen1;
    logic [4:0]    waddr1;
    logic [DW-1:0] wdata1;
    logic          redirect_valid;
    logic [DW-1:0] redirect_pc;

    row_t        rows[$];
    logic [31:0] div_a[$];
    logic [31:0] div_b[$];
    logic [31:0] lfsr_state;

    // csr shadow state of the reference model
    logic [31:0] sh_estat;
    logic [31:0] sh_era;
    logic [31:0] sh_badv;
    logic [31:0] sh_eentry;
    logic [31:0] sh_save0;

    exec_backend #(.DATA_WIDTH(DW)) UUT (.*);

    bind writeback_stage exec_backend_properties u_props (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped on timeout");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [31:0] pc_of(input int i);
        return 32'h1c001000 + 32'(i) * 32'd8;
    endfunction

    task automatic add_row(input op_e op, input logic [4:0] rd0_v, input logic [31:0] data0_v,
                           input csr_num_e csr_v, input logic zero_v, input logic lane1_v,
                           input logic [4:0] rd1_v, input logic [31:0] res1_v,
                           input logic w0, input logic w1, input logic rdr);
        row_t        r;
        logic [31:0] a;
        logic [31:0] b;
        r = '{op, rd0_v, data0_v, csr_v, zero_v, lane1_v, rd1_v, res1_v, w0, w1, rdr};
        a = '0;
        b = '0;
        if (op == op_div || op == op_mod) begin
            draw_bits(32, a);
            if (!zero_v) begin
                draw_bits(12, b);
            end
        end
        rows.push_back(r);
        div_a.push_back(a);
        div_b.push_back(b);
    endtask

    // op, rd0, data0, csr, zero divisor, lane1, rd1, result1, wen0, wen1, redirect
    task automatic build_table();
        add_row(op_alu, 5'd1, 32'h11111111, csr_save0, 0, 1, 5'd2, 32'h22222222, 1, 1, 0);
        add_row(op_alu, 5'd3, 32'h3c3c0003, csr_save0, 0, 1, 5'd4, 32'h4b4b0004, 1, 1, 0);
        add_row(op_div, 5'd5, 32'h0, csr_save0, 0, 1, 5'd6, 32'h66660006, 1, 1, 0);
        add_row(op_mod, 5'd7, 32'h0, csr_save0, 0, 1, 5'd8, 32'h88880008, 1, 1, 0);
        add_row(op_div, 5'd9, 32'h0, csr_save0, 1, 0, 5'd0, 32'h0, 1, 0, 0);
        add_row(op_mod, 5'd10, 32'h0, csr_save0, 1, 1, 5'd11, 32'hbbbb000b, 1, 1, 0);
        add_row(op_csrxchg, 5'd12, 32'hcafe0001, csr_save0, 0, 0, 5'd0, 32'h0, 1, 0, 0);
        add_row(op_csrxchg, 5'd13, 32'h5a5a0002, csr_save0, 0, 1, 5'd14, 32'hdddd000e, 1, 1, 0);
        add_row(op_csrrd, 5'd15, 32'h0, csr_save0, 0, 0, 5'd0, 32'h0, 1, 0, 0);
        add_row(op_syscall, 5'd0, 32'h0, csr_save0, 0, 1, 5'd16, 32'h10100010, 0, 0, 1);
        add_row(op_csrrd, 5'd17, 32'h0, csr_era, 0, 0, 5'd0, 32'h0, 1, 0, 0);
        add_row(op_csrrd, 5'd18, 32'h0, csr_estat, 0, 0, 5'd0, 32'h0, 1, 0, 0);
        add_row(op_ertn, 5'd0, 32'h0, csr_save0, 0, 1, 5'd19, 32'h13130013, 0, 1, 1);
        add_row(op_csrxchg, 5'd20, 32'h1c008000, csr_eentry, 0, 0, 5'd0, 32'h0, 1, 0, 0);
        add_row(op_syscall, 5'd0, 32'h0, csr_save0, 0, 1, 5'd21, 32'h15150015, 0, 0, 1);
        add_row(op_csrrd, 5'd26, 32'h0, csr_era, 0, 0, 5'd0, 32'h0, 1, 0, 0);
        add_row(op_ertn, 5'd0, 32'h0, csr_save0, 0, 0, 5'd0, 32'h0, 0, 0, 1);
        add_row(op_div, 5'd22, 32'h0, csr_save0, 0, 1, 5'd23, 32'h17170017, 1, 1, 0);
        add_row(op_alu, 5'd24, 32'h18180018, csr_save0, 0, 0, 5'd0, 32'h0, 1, 0, 0);
        add_row(op_nop, 5'd0, 32'h0, csr_save0, 0, 1, 5'd25, 32'h19190019, 0, 1, 0);
    endtask

    function automatic logic [31:0] shadow_read(input csr_num_e n);
        case (n)
            csr_estat:  return sh_estat;
            csr_era:    return sh_era;
            csr_badv:   return sh_badv;
            csr_eentry: return sh_eentry;
            csr_save0:  return sh_save0;
            default:    return 32'h0;
        endcase
    endfunction

    task automatic shadow_write(input csr_num_e n, input logic [31:0] v);
        case (n)
            csr_estat:  sh_estat = v;
            csr_era:    sh_era = v;
            csr_badv:   sh_badv = v;
            csr_eentry: sh_eentry = v;
            csr_save0:  sh_save0 = v;
            default:    sh_save0 = sh_save0;
        endcase
    endtask

    // expected lane-0 data and redirect target, shadow updated at acceptance
    task automatic model_row(input int i, output logic [31:0] exp0, output logic [31:0] exp_pc);
        row_t r;
        r = rows[i];
        exp0 = 32'h0;
        exp_pc = 32'h0;
        case (r.op)
            op_alu:  exp0 = r.data0;
            op_div:  exp0 = (div_b[i] == 0) ? 32'hffffffff : div_a[i] / div_b[i];
            op_mod:  exp0 = (div_b[i] == 0) ? div_a[i] : div_a[i] % div_b[i];
            op_csrrd: exp0 = shadow_read(r.csr);
            op_csrxchg: begin
                exp0 = shadow_read(r.csr);
                shadow_write(r.csr, r.data0);
            end
            op_syscall: begin
                exp_pc = sh_eentry;
                sh_era = pc_of(i);
                sh_estat[21:16] = ecode_sys;
                sh_estat[3] = sh_estat[2];
                sh_estat[2] = 1'b0;
            end
            op_ertn: begin
                exp_pc = sh_era;
                sh_estat[2] = sh_estat[3];
            end
            default: exp0 = 32'h0;
        endcase
    endtask

    task automatic drive_row(input int i);
        issue_valid = 1'b1;
        op0         = rows[i].op;
        pc0         = pc_of(i);
        pc1         = pc_of(i) + 32'd4;
        rd0         = rows[i].rd0;
        result0     = rows[i].data0;
        csr_num     = rows[i].csr;
        csr_wdata   = rows[i].data0;
        dividend    = div_a[i];
        divisor     = div_b[i];
        lane1_valid = rows[i].lane1;
        rd1         = rows[i].rd1;
        result1     = rows[i].result1;
    endtask

    task automatic wait_allowin();
        int cycles;
        cycles = 0;
        while (!allowin) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ALLOW_LIMIT) begin
                report_timeout("allowin");
            end
        end
    endtask

    task automatic check_issue_cycle(input int i, input logic [31:0] exp0,
                                     input logic [31:0] exp_pc);
        row_t r;
        logic div_row;
        r = rows[i];
        div_row = (r.op == op_div) || (r.op == op_mod);
        assert (wen0 == (r.exp_wen0 && !div_row))
        else report_mismatch($sformatf("row %0d: wen0 is %0b", i, wen0));
        if (wen0) begin
            assert (waddr0 == r.rd0 && wdata0 == exp0)
            else report_mismatch($sformatf("row %0d: lane 0 r%0d=%08h, expected r%0d=%08h",
                                           i, waddr0, wdata0, r.rd0, exp0));
        end
        assert (wen1 == r.exp_wen1)
        else report_mismatch($sformatf("row %0d: wen1 is %0b", i, wen1));
        if (wen1) begin
            assert (waddr1 == r.rd1 && wdata1 == r.result1)
            else report_mismatch($sformatf("row %0d: lane 1 r%0d=%08h, expected r%0d=%08h",
                                           i, waddr1, wdata1, r.rd1, r.result1));
        end
        assert (redirect_valid == r.exp_redir)
        else report_mismatch($sformatf("row %0d: redirect_valid is %0b", i, redirect_valid));
        if (redirect_valid) begin
            assert (redirect_pc == exp_pc)
            else report_mismatch($sformatf("row %0d: redirect to %08h, expected %08h",
                                           i, redirect_pc, exp_pc));
        end
        assert (allowin == !div_row)
        else report_mismatch($sformatf("row %0d: allowin is %0b", i, allowin));
    endtask

    // next row is held on the inputs meanwhile and must not be taken
    task automatic wait_div_write(input int i, input logic [31:0] exp0);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            #1;
            cycles++;
            if (wen0) begin
                seen = 1'b1;
            end else begin
                assert (!allowin && !wen1 && !redirect_valid)
                else report_mismatch($sformatf("row %0d: activity while divide pending", i));
                if (cycles > DIV_LIMIT) begin
                    report_timeout("the divide result");
                end
            end
        end
        assert (cycles == DIV_LATENCY)
        else report_mismatch($sformatf("row %0d: divide wrote after %0d cycles", i, cycles));
        assert (allowin && !wen1 && !redirect_valid)
        else report_mismatch($sformatf("row %0d: bad allowin or lane 1 at divide write", i));
        assert (waddr0 == rows[i].rd0 && wdata0 == exp0)
        else report_mismatch($sformatf("row %0d: divide r%0d=%08h, expected r%0d=%08h",
                                       i, waddr0, wdata0, rows[i].rd0, exp0));
    endtask

    initial begin
        int          i;
        logic [31:0] exp0;
        logic [31:0] exp_pc;
        logic        div_row;
        aresetn     = 1'b0;
        issue_valid = 1'b0;
        pc0         = '0;
        pc1         = '0;
        op0         = op_nop;
        rd0         = '0;
        result0     = '0;
        csr_num     = csr_save0;
        csr_wdata   = '0;
        dividend    = '0;
        divisor     = '0;
        lane1_valid = 1'b0;
        rd1         = '0;
        result1     = '0;
        lfsr_state  = 32'hda90;
        sh_estat    = '0;
        sh_era      = '0;
        sh_badv     = '0;
        sh_eentry   = 32'h1c000000;
        sh_save0    = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        assert (!wen0 && !wen1 && !redirect_valid && allowin)
        else report_mismatch("outputs not at their reset values");
        aresetn = 1'b1;
        for (i = 0; i < rows.size(); i++) begin
            drive_row(i);
            wait_allowin();
            @(posedge clk);
            #1;
            model_row(i, exp0, exp_pc);
            div_row = (rows[i].op == op_div) || (rows[i].op == op_mod);
            if (div_row && i + 1 < rows.size()) begin
                drive_row(i + 1);
            end else begin
                issue_valid = 1'b0;
            end
            check_issue_cycle(i, exp0, exp_pc);
            if (div_row) begin
                wait_div_write(i, exp0);
            end
        end
        issue_valid = 1'b0;
        repeat (3) @(posedge clk);
        if (UUT.u_wb.u_props.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d bound assertion failures", UUT.u_wb.u_props.fail_count);
            $display("*** TEST FAILED ***");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- files.f
hdl/wb_pkg.sv
hdl/int_divider.sv
hdl/csr_unit.sv
hdl/writeback_stage.sv
hdl/exec_backend.sv
bench/exec_backend_properties.sv
bench/exec_backend_tb.sv

//--- Bender.yml
package:
  name: exec_backend

sources:
  - files:
      - hdl/wb_pkg.sv
      - hdl/int_divider.sv
      - hdl/csr_unit.sv
      - hdl/writeback_stage.sv
      - hdl/exec_backend.sv
  - target: test
    files:
      - bench/exec_backend_properties.sv
      - bench/exec_backend_tb.sv
